//--- bench/pad_event_checks.svh
// error reporting and compare tasks for change and snapshot records

// plain failure text, then the run ends
task automatic stop_run(input string reason);
	$display("%s", reason);
	$display("Something failed");
	$fatal(1, "run stopped at the first error");
endtask

// wrong value, with time stamp
task automatic value_error(input string msg);
	stop_run($sformatf("ERROR at %0t ns: %s", $time, msg));
endtask

// whole record, reserved bits included
task automatic check_change(input pad_event_pkg::pad_change_t got,
	input pad_event_pkg::pad_change_t want);
	if (got !== want)
		value_error($sformatf(
			"change record %03h (button %0d pressed %0b), expected %03h (button %0d pressed %0b)",
			got, got.button, got.pressed, want, want.button, want.pressed));
endtask

task automatic check_snapshot(input pad_event_pkg::pad_snapshot_t got,
	input pad_event_pkg::pad_snapshot_t want);
	if (got !== want)
		value_error($sformatf("snapshot record buttons %02h, expected %02h",
			got.buttons, want.buttons));
endtask

//--- bench/pad_event_tb.sv
// testbench: clock, reset, pad model, stimulus table, consumer, scoreboard and watchdog
`timescale 1ns/100ps

module pad_event_tb;

	// one poll per row
	typedef struct packed
	{
		logic [7:0] buttons;
		logic withhold;
		logic mid_tick;
	} row_t;

	localparam int row_count = 9;
	localparam int watchdog_ns = row_count * (pad_timing_pkg::poll_cycles + 200) * 8 * 2;

	// rows 3 to 5 fill the queue, row 5 is dropped, row 6 resyncs
	row_t stim [row_count] = '{
		'{8'h00, 1'b0, 1'b0},
		'{8'h81, 1'b0, 1'b1},
		'{8'h81, 1'b0, 1'b0},
		'{8'h7e, 1'b1, 1'b0},
		'{8'h81, 1'b1, 1'b0},
		'{8'h7e, 1'b1, 1'b0},
		'{8'h3c, 1'b0, 1'b0},
		'{8'h24, 1'b0, 1'b1},
		'{8'h25, 1'b0, 1'b0}
	};

	logic clock = 1'b0;
	logic reset;
	logic frame_tick;
	logic pad_data;
	logic pad_latch;
	logic pad_pulse;
	logic out_valid;
	pad_event_pkg::pad_event_t out_word;
	logic credit_return = 1'b0;

	// pad model, released is 1 on the wire
	logic [7:0] pad_buttons;
	logic [7:0] pad_shift = 8'hff;
	logic pulse_seen;

	// waveform monitor
	logic latch_q;
	logic pulse_q;
	int latch_len;
	int latch_rises;
	int pulse_rises;

	// consumer side
	logic withhold;
	int cycle_no;
	int outstanding;
	int credit_due [$];
	pad_event_pkg::pad_event_t expected_q [$];

	// reference model state
	logic [7:0] ref_last;
	logic ref_resync;
	int ref_queued;
	int ref_credits;

	`include "pad_event_checks.svh"

	pad_event_top dut_i
	(
		.clock         (clock),
		.reset         (reset),
		.frame_tick    (frame_tick),
		.pad_data      (pad_data),
		.pad_latch     (pad_latch),
		.pad_pulse     (pad_pulse),
		.out_valid     (out_valid),
		.out_word      (out_word),
		.credit_return (credit_return)
	);

	always #4 clock = ~clock;

	//////////////////////////////////////////////////
	// pad shift register and waveform monitor
	//////////////////////////////////////////////////

	// loads while latched, shifts on each pulse rise
	always @(posedge clock)
	begin
		pulse_seen <= pad_pulse;
		if (pad_latch)
			pad_shift <= ~pad_buttons;
		else if (pad_pulse && !pulse_seen)
			pad_shift <= {pad_shift[6:0], 1'b1};
	end

	assign pad_data = pad_shift[7];

	always @(posedge clock)
	begin
		if (reset)
		begin
			latch_q <= 1'b0;
			pulse_q <= 1'b0;
			latch_len <= 0;
			latch_rises <= 0;
			pulse_rises <= 0;
		end
		else
		begin
			latch_q <= pad_latch;
			pulse_q <= pad_pulse;
			if (pad_latch && !latch_q)
			begin
				// the poll before must have had seven pulses
				if (latch_rises != 0 && pulse_rises != 7)
					value_error($sformatf("%0d pulse rises in one poll, expected 7", pulse_rises));
				latch_rises <= latch_rises + 1;
				pulse_rises <= 0;
			end
			else if (pad_pulse && !pulse_q)
				pulse_rises <= pulse_rises + 1;
			if (pad_latch)
				latch_len <= latch_len + 1;
			else
			begin
				latch_len <= 0;
				if (latch_q && latch_len != int'(pad_timing_pkg::latch_cycles))
					value_error($sformatf("latch high for %0d cycles, expected %0d",
						latch_len, pad_timing_pkg::latch_cycles));
			end
		end
	end

	//////////////////////////////////////////////////
	// consumer and scoreboard
	//////////////////////////////////////////////////

	// kind bit first, then the matching view
	task automatic compare_word(input pad_event_pkg::pad_event_t got);
		pad_event_pkg::pad_event_t want;
		if (expected_q.size() == 0)
			stop_run("a word came out while no record was expected");
		else
		begin
			want = expected_q.pop_front();
			if (got.change.kind !== want.change.kind)
				value_error($sformatf("record kind %0b, expected %0b",
					got.change.kind, want.change.kind));
			else if (want.change.kind == pad_event_pkg::kind_change)
				check_change(got.change, want.change);
			else
				check_snapshot(got.snapshot, want.snapshot);
		end
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			cycle_no = 0;
			outstanding = 0;
			credit_return <= 1'b0;
		end
		else
		begin
			cycle_no++;
			credit_return <= 1'b0;
			if (out_valid)
			begin
				compare_word(out_word);
				outstanding++;
				if (outstanding > int'(pad_event_pkg::credits_max))
					value_error($sformatf("%0d words outstanding, credit limit %0d",
						outstanding, pad_event_pkg::credits_max));
				credit_due.push_back(cycle_no + int'($urandom_range(20, 1)));
			end
			// one return per cycle, none while withheld
			if (!withhold && credit_due.size() != 0 && credit_due[0] <= cycle_no)
			begin
				void'(credit_due.pop_front());
				outstanding--;
				credit_return <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// reference model and row sequence
	//////////////////////////////////////////////////

	// records one poll should yield, and queue fill at its decision
	task automatic predict_poll(input row_t row);
		logic [7:0] diff;
		int needed;
		int sent;
		pad_timing_pkg::btn_idx_t idx;
		pad_event_pkg::pad_event_t rec;
		diff = row.buttons ^ ref_last;
		needed = ref_resync ? 1 : $countones(diff);
		// free-running credits drain the queue long before the decision
		if (!row.withhold)
		begin
			ref_queued = 0;
			ref_credits = int'(pad_event_pkg::credits_max);
		end
		if (needed > int'(pad_event_pkg::queue_depth) - ref_queued)
			ref_resync = 1'b1;
		else
		begin
			if (ref_resync)
			begin
				rec.snapshot = '{kind: pad_event_pkg::kind_snapshot, buttons: row.buttons};
				expected_q.push_back(rec);
				ref_resync = 1'b0;
			end
			else
			begin
				for (int i = 7; i >= 0; i--)
				begin
					idx = pad_timing_pkg::btn_idx_t'(i);
					if (diff[idx])
					begin
						rec.change = '{kind: pad_event_pkg::kind_change, reserved: 4'd0,
							button: idx, pressed: row.buttons[idx]};
						expected_q.push_back(rec);
					end
				end
			end
			ref_queued += needed;
			ref_last = row.buttons;
		end
		// withheld credits cap what leaves the queue
		sent = (ref_credits < ref_queued) ? ref_credits : ref_queued;
		ref_queued -= sent;
		ref_credits -= sent;
	endtask

	task automatic run_row(input row_t row);
		predict_poll(row);
		pad_buttons <= row.buttons;
		withhold <= row.withhold;
		frame_tick <= 1'b1;
		@(posedge clock);
		frame_tick <= 1'b0;
		while (!pad_latch)
			@(posedge clock);
		// second tick lands inside the latch phase
		if (row.mid_tick)
		begin
			repeat (100) @(posedge clock);
			frame_tick <= 1'b1;
			@(posedge clock);
			frame_tick <= 1'b0;
		end
		while (pad_latch)
			@(posedge clock);
		while (pulse_rises < 7 || pad_pulse)
			@(posedge clock);
		repeat (20) @(posedge clock);
	endtask

	initial
	begin
		void'($urandom(32'h6e34131c));
		reset = 1'b1;
		frame_tick = 1'b0;
		withhold = 1'b0;
		pad_buttons = 8'h00;
		ref_last = 8'h00;
		ref_resync = 1'b1;
		ref_queued = 0;
		ref_credits = int'(pad_event_pkg::credits_max);
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		if (pad_latch !== 1'b0 || pad_pulse !== 1'b0)
			stop_run("pad latch or pulse was not low after reset");
		for (int r = 0; r < row_count; r++)
			run_row(stim[r]);
		while (expected_q.size() != 0)
			@(posedge clock);
		repeat (100) @(posedge clock);
		if (latch_rises == row_count && pulse_rises == 7)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			value_error($sformatf(
				"%0d latch rises and %0d pulses in the last poll, expected %0d and 7",
				latch_rises, pulse_rises, row_count));
	end

	// limit from the number of polls
	initial
	begin
		#(watchdog_ns);
		stop_run("watchdog expired before the test sequence finished");
	end

endmodule

//--- hdl/pad_change_detector.sv
// change detector: poll compare, change or snapshot records, queue fit check and resync
`timescale 1ns/100ps

module pad_change_detector
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       snap_valid,
	input  logic [7:0]                 snap_buttons,
	input  pad_event_pkg::free_t       free_slots,
	output logic                       evt_push,
	output pad_event_pkg::pad_event_t  evt_word
);

	logic [7:0] last_buttons;
	logic [7:0] new_buttons;
	logic [7:0] diff;
	// changes still to be pushed
	logic [7:0] pending;
	logic resync;
	logic deciding;
	logic snap_due;
	logic [3:0] needed;
	logic accept;
	logic push_snap;
	logic push_change;
	pad_timing_pkg::btn_idx_t top_idx;
	pad_event_pkg::pad_change_t change_rec;
	pad_event_pkg::pad_snapshot_t snap_rec;

	// number of set bits, 0 to 8
	function automatic logic [3:0] count_ones(input logic [7:0] mask);
		logic [3:0] total;
		total = 4'd0;
		for (int i = 0; i < 8; i++)
			total = total + {3'd0, mask[i]};
		return total;
	endfunction

	// index of the highest set bit, upward scan so the top one wins
	function automatic pad_timing_pkg::btn_idx_t highest_bit(input logic [7:0] mask);
		pad_timing_pkg::btn_idx_t idx;
		idx = pad_timing_pkg::btn_right;
		for (int i = 0; i < 8; i++)
			if (mask[i])
				idx = pad_timing_pkg::btn_idx_t'(i);
		return idx;
	endfunction

	//////////////////////////////////////////////////
	// fit decision
	//////////////////////////////////////////////////

	assign diff = new_buttons ^ last_buttons;
	// a resync always costs exactly one record
	assign needed = resync ? 4'd1 : count_ones(diff);
	// whole poll or nothing
	assign accept = ({1'b0, needed} <= free_slots);

	// one push per cycle, none in the decision cycle
	assign push_snap = !deciding && snap_due;
	assign push_change = !deciding && !snap_due && (pending != 8'd0);

	assign top_idx = highest_bit(pending);
	assign change_rec = '{kind: pad_event_pkg::kind_change, reserved: 4'd0,
		button: top_idx, pressed: last_buttons[top_idx]};
	assign snap_rec = '{kind: pad_event_pkg::kind_snapshot, buttons: last_buttons};

	// poll held for the decision cycle
	always_ff @(posedge clock)
	begin
		if (snap_valid)
			new_buttons <= snap_buttons;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// start from all released and force a snapshot
			last_buttons <= 8'd0;
			pending <= 8'd0;
			resync <= 1'b1;
			deciding <= 1'b0;
			snap_due <= 1'b0;
			evt_push <= 1'b0;
		end
		else
		begin
			deciding <= snap_valid;
			evt_push <= push_snap || push_change;
			if (deciding)
			begin
				if (accept)
				begin
					last_buttons <= new_buttons;
					if (resync)
						snap_due <= 1'b1;
					else
						pending <= diff;
				end
				else
					resync <= 1'b1;
			end
			if (push_snap)
			begin
				snap_due <= 1'b0;
				resync <= 1'b0;
			end
			if (push_change)
				pending[top_idx] <= 1'b0;
		end
	end

	// record word goes out with evt_push
	always_ff @(posedge clock)
	begin
		if (push_snap)
			evt_word.snapshot <= snap_rec;
		else if (push_change)
			evt_word.change <= change_rec;
	end

endmodule

//--- hdl/pad_event_pkg.sv
// button event record types, event word union, queue depth and credit count
package pad_event_pkg;

	//////////////////////////////////////////////////
	// record kinds
	//////////////////////////////////////////////////

	localparam logic kind_change = 1'b0;
	localparam logic kind_snapshot = 1'b1;

	// one button went up or down
	typedef struct packed
	{
		logic kind;
		// always zero
		logic [3:0] reserved;
		logic [2:0] button;
		// new state, 1 for pressed
		logic pressed;
	} pad_change_t;

	// full button state, 1 for pressed
	typedef struct packed
	{
		logic kind;
		logic [7:0] buttons;
	} pad_snapshot_t;

	// kind bit sits at bit 8 in both views,
	// so the consumer checks it before picking a view
	typedef union packed
	{
		pad_change_t change;
		pad_snapshot_t snapshot;
	} pad_event_t;

	//////////////////////////////////////////////////
	// queue and flow control
	//////////////////////////////////////////////////

	// free slot count, 0 to queue_depth
	typedef logic [4:0] free_t;
	// credit count, 0 to credits_max
	typedef logic [2:0] credit_t;

	localparam free_t queue_depth = 5'd16;
	localparam credit_t credits_max = 3'd4;

endpackage

//--- hdl/pad_event_sender.sv
// event sender: circular event queue and credit counter for the consumer port
`timescale 1ns/100ps

module pad_event_sender
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       evt_push,
	input  pad_event_pkg::pad_event_t  evt_word,
	output pad_event_pkg::free_t       free_slots,
	output logic                       out_valid,
	output pad_event_pkg::pad_event_t  out_word,
	input  logic                       credit_return
);

	pad_event_pkg::pad_event_t queue_mem [pad_event_pkg::queue_depth];
	logic [$clog2(pad_event_pkg::queue_depth)-1:0] wr_ptr;
	logic [$clog2(pad_event_pkg::queue_depth)-1:0] rd_ptr;
	// words held in the queue
	pad_event_pkg::free_t count;
	pad_event_pkg::credit_t credits;
	logic push_ok;
	logic pop;

	//////////////////////////////////////////////////
	// queue
	//////////////////////////////////////////////////

	assign free_slots = pad_event_pkg::queue_depth - count;
	// detector never overfills, guarded anyway
	assign push_ok = evt_push && (free_slots != 5'd0);

	always_ff @(posedge clock)
	begin
		if (push_ok)
			queue_mem[wr_ptr] <= evt_word;
	end

	// pointers wrap on their own at 16 entries
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 5'd0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// credit flow to the consumer
	//////////////////////////////////////////////////

	// head word leaves whenever a credit is in hand,
	// so a push is visible one cycle later
	assign out_valid = (count != 5'd0) && (credits != 3'd0);
	assign out_word = queue_mem[rd_ptr];
	assign pop = out_valid;

	// one credit per word sent, one back per return cycle
	always_ff @(posedge clock)
	begin
		if (reset)
			credits <= pad_event_pkg::credits_max;
		else
		begin
			case ({pop, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

//--- hdl/pad_event_top.sv
// top level: pad reader, change detector and event sender
`timescale 1ns/100ps

module pad_event_top
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       frame_tick,
	input  logic                       pad_data,
	output logic                       pad_latch,
	output logic                       pad_pulse,
	output logic                       out_valid,
	output pad_event_pkg::pad_event_t  out_word,
	input  logic                       credit_return
);

	// reader to detector
	logic snap_valid;
	logic [7:0] snap_buttons;
	// detector to sender and back
	logic evt_push;
	pad_event_pkg::pad_event_t evt_word;
	pad_event_pkg::free_t free_slots;

	//////////////////////////////////////////////////
	// pad side
	//////////////////////////////////////////////////

	pad_serial_reader reader_i
	(
		.clock        (clock),
		.reset        (reset),
		.frame_tick   (frame_tick),
		.pad_data     (pad_data),
		.pad_latch    (pad_latch),
		.pad_pulse    (pad_pulse),
		.snap_valid   (snap_valid),
		.snap_buttons (snap_buttons)
	);

	// poll compare, sees free space of the queue
	pad_change_detector detector_i
	(
		.clock        (clock),
		.reset        (reset),
		.snap_valid   (snap_valid),
		.snap_buttons (snap_buttons),
		.free_slots   (free_slots),
		.evt_push     (evt_push),
		.evt_word     (evt_word)
	);

	//////////////////////////////////////////////////
	// consumer side
	//////////////////////////////////////////////////

	pad_event_sender sender_i
	(
		.clock         (clock),
		.reset         (reset),
		.evt_push      (evt_push),
		.evt_word      (evt_word),
		.free_slots    (free_slots),
		.out_valid     (out_valid),
		.out_word      (out_word),
		.credit_return (credit_return)
	);

endmodule

//--- hdl/pad_serial_reader.sv
// game pad reader: latch and pulse generation, serial sampling, snapshot assembly
`timescale 1ns/100ps

module pad_serial_reader
(
	input  logic       clock,
	input  logic       reset,
	input  logic       frame_tick,
	input  logic       pad_data,
	output logic       pad_latch,
	output logic       pad_pulse,
	output logic       snap_valid,
	output logic [7:0] snap_buttons
);

	// one phase of the pad waveform
	typedef enum logic [1:0]
	{
		st_idle,
		st_latch,
		st_low,
		st_high
	} phase_t;

	phase_t state;
	// cycles left in the current phase, ends at 1
	pad_timing_pkg::cycle_t cycle_cnt;
	// next bit to be sampled
	pad_timing_pkg::btn_idx_t bit_idx;
	logic [pad_timing_pkg::button_count-1:0] shift_reg;
	logic phase_end;
	logic sample;

	//////////////////////////////////////////////////
	// phase decode
	//////////////////////////////////////////////////

	// pins follow the phase directly
	assign pad_latch = (state == st_latch);
	assign pad_pulse = (state == st_high);

	// last cycle of any active phase
	assign phase_end = (state != st_idle) && (cycle_cnt == pad_timing_pkg::cycle_t'(1));

	// pad shifts on the pulse rise, so the new bit is stable by the end of the high half,
	// and bit 7 is already out during the latch
	assign sample = phase_end && ((state == st_latch) || (state == st_high));

	//////////////////////////////////////////////////
	// phase sequence
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= st_idle;
			snap_valid <= 1'b0;
		end
		else
		begin
			// strobe right after the bit 0 sample
			snap_valid <= sample && (bit_idx == pad_timing_pkg::btn_right);
			case (state)
				st_idle:
				begin
					// ticks are only seen here, so a tick mid poll is lost
					if (frame_tick)
						state <= st_latch;
				end
				st_latch:
				begin
					if (phase_end)
						state <= st_low;
				end
				st_low:
				begin
					if (phase_end)
						state <= st_high;
				end
				default:
				begin
					// bit 0 is taken at the end of the last high half
					if (phase_end)
					begin
						if (bit_idx == pad_timing_pkg::btn_right)
							state <= st_idle;
						else
							state <= st_low;
					end
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// cycle and bit counters
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			cycle_cnt <= pad_timing_pkg::latch_cycles;
			bit_idx <= pad_timing_pkg::btn_a;
		end
		else if (state == st_idle)
		begin
			// held ready for the next poll
			cycle_cnt <= pad_timing_pkg::latch_cycles;
			bit_idx <= pad_timing_pkg::btn_a;
		end
		else
		begin
			// every phase after the latch is a half bit long
			if (phase_end)
				cycle_cnt <= pad_timing_pkg::half_bit_cycles;
			else
				cycle_cnt <= cycle_cnt - 1'b1;
			if (sample)
				bit_idx <= bit_idx - 1'b1;
		end
	end

	// pad data is active low, bit 7 ends up on top
	always_ff @(posedge clock)
	begin
		if (sample)
			shift_reg <= {shift_reg[pad_timing_pkg::button_count-2:0], ~pad_data};
	end

	assign snap_buttons = shift_reg;

endmodule

//--- hdl/pad_timing_pkg.sv
// game pad waveform timing constants, counter types and button bit positions
package pad_timing_pkg;

	//////////////////////////////////////////////////
	// counter types
	//////////////////////////////////////////////////

	// wide enough for the longest phase, the latch
	typedef logic [10:0] cycle_t;
	// index of one button in a snapshot
	typedef logic [2:0] btn_idx_t;

	//////////////////////////////////////////////////
	// waveform timing at 125 MHz
	//////////////////////////////////////////////////

	// latch high for 12 us
	localparam cycle_t latch_cycles = 11'd1500;
	// half of one 12 us pulse period
	localparam cycle_t half_bit_cycles = 11'd750;
	localparam int button_count = 8;

	// bit positions, first shifted out at the top
	localparam btn_idx_t btn_a = 3'd7;
	localparam btn_idx_t btn_b = 3'd6;
	localparam btn_idx_t btn_select = 3'd5;
	localparam btn_idx_t btn_start = 3'd4;
	localparam btn_idx_t btn_up = 3'd3;
	localparam btn_idx_t btn_down = 3'd2;
	localparam btn_idx_t btn_left = 3'd1;
	localparam btn_idx_t btn_right = 3'd0;

	// whole poll, latch plus seven pulses of two halves each
	localparam int poll_cycles = int'(latch_cycles) + 14 * int'(half_bit_cycles);

endpackage

//--- list.f
+incdir+bench
hdl/pad_timing_pkg.sv
hdl/pad_event_pkg.sv
hdl/pad_serial_reader.sv
hdl/pad_change_detector.sv
hdl/pad_event_sender.sv
hdl/pad_event_top.sv
bench/pad_event_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, exit status gives the result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --top-module pad_event_tb -f list.f -o pad_event_sim \
	&& ./obj_dir/pad_event_sim \
	|| exit 1
